// ==== include/nabp_macros.svh ====
`ifndef NABP_MACROS_SVH
`define NABP_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// sample address within a row
`define NABP_S_LENGTH 4
// unsigned raw sample from host RAM
`define NABP_RAW_LENGTH 12
// signed sample after the ramp filter
`define NABP_FILTERED_LENGTH 16
// angle index
`define NABP_ANGLE_LENGTH 8
// rotation pointer, wide enough for the buffer count
`define NABP_ROTATE_LENGTH 2

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// depths and delays
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// samples per row
`define NABP_S_DEPTH 16
// address to filtered data: 1 cycle host RAM, 2 cycles filter
`define NABP_FILL_DELAY 3
// rotating buffers
`define NABP_SWAP_COUNT 3

`endif

// ==== verilog/nabp_pkg.sv ====
`default_nettype none

`include "nabp_macros.svh"

package nabp_pkg;

    // sample address, one row of 16
    typedef logic [`NABP_S_LENGTH-1:0] s_addr_t;

    // raw sample as stored by the host
    typedef logic [`NABP_RAW_LENGTH-1:0] raw_t;

    // filtered sample, can go negative
    typedef logic signed [`NABP_FILTERED_LENGTH-1:0] filtered_t;

    // angle index handed to the processors
    typedef logic [`NABP_ANGLE_LENGTH-1:0] angle_t;

    // points at the buffer being filled
    typedef logic [`NABP_ROTATE_LENGTH-1:0] rotate_sel_t;

    // buffer rotation FSM
    typedef enum logic [2:0] {
        ready_s,
        fill_s,
        fill_and_work_s,
        fill_and_work_repeat_s,
        work_1_s,
        work_2_s
    } swap_state_t;

endpackage

`default_nettype wire

// ==== verilog/swap_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface swap_port_if ();

    // fill handshake
    logic fill_kick;
    logic fill_done;

    // host side of the fill
    nabp_pkg::s_addr_t hs_s_val;
    nabp_pkg::filtered_t hs_val;

    // two read ports toward the processors
    nabp_pkg::s_addr_t pr0_s_val;
    nabp_pkg::s_addr_t pr1_s_val;
    nabp_pkg::filtered_t pr0_val;
    nabp_pkg::filtered_t pr1_val;

    // swap control end
    modport control (
        output fill_kick, hs_val, pr0_s_val, pr1_s_val,
        input  fill_done, hs_s_val, pr0_val, pr1_val
    );

    // buffer end
    modport swappable (
        input  fill_kick, hs_val, pr0_s_val, pr1_s_val,
        output fill_done, hs_s_val, pr0_val, pr1_val
    );

endinterface

`default_nettype wire

// ==== verilog/nabp_ramp_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

module nabp_ramp_filter (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                clear,
    input  nabp_pkg::raw_t      raw,
    output nabp_pkg::filtered_t filtered
);

    // tap registers, x[a], x[a-1], x[a-2]
    nabp_pkg::raw_t x_cur;
    nabp_pkg::raw_t x_p1;
    nabp_pkg::raw_t x_p2;

    // zero extended into the signed domain
    nabp_pkg::filtered_t cur_ext;
    nabp_pkg::filtered_t p1_ext;
    nabp_pkg::filtered_t p2_ext;

    assign cur_ext = nabp_pkg::filtered_t'(x_cur);
    assign p1_ext = nabp_pkg::filtered_t'(x_p1);
    assign p2_ext = nabp_pkg::filtered_t'(x_p2);

    // tap stage
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            x_cur <= '0;
            x_p1 <= '0;
            x_p2 <= '0;
        end
        else
        begin
            x_cur <= raw;
            // clear comes with the first sample of a row
            // so history before it reads as zero
            if (clear)
            begin
                x_p1 <= '0;
                x_p2 <= '0;
            end
            else
            begin
                x_p1 <= x_cur;
                x_p2 <= x_p1;
            end
        end
    end

    // sum stage, y = 2x[a] - x[a-1] - x[a-2]
    always_ff @(posedge clk)
    begin
        filtered <= (cur_ext <<< 1) - p1_ext - p2_ext;
    end

endmodule

`default_nettype wire

// ==== verilog/nabp_filtered_ram_swappable.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nabp_macros.svh"

module nabp_filtered_ram_swappable (
    input logic            clk,
    input logic            reset_n,
    swap_port_if.swappable port
);

    // one filtered row
    nabp_pkg::filtered_t mem [`NABP_S_DEPTH];

    // fill address generator
    logic fill_active;
    nabp_pkg::s_addr_t fill_addr;

    // address follows the data through RAM and filter
    logic [`NABP_FILL_DELAY-1:0] dly_valid;
    nabp_pkg::s_addr_t dly_addr [`NABP_FILL_DELAY];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fill side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign port.hs_s_val = fill_addr;

    // counts 0..15 in the 16 cycles after a kick
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            fill_active <= 1'b0;
            fill_addr <= '0;
        end
        else if (port.fill_kick)
        begin
            fill_active <= 1'b1;
            fill_addr <= '0;
        end
        else if (fill_active)
        begin
            if (fill_addr == nabp_pkg::s_addr_t'(`NABP_S_DEPTH - 1))
                fill_active <= 1'b0;
            else
                fill_addr <= fill_addr + 1'b1;
        end
    end

    // valid bits of the delay line
    always_ff @(posedge clk)
    begin
        if (reset_n)
            dly_valid <= '0;
        else
            dly_valid <= {dly_valid[`NABP_FILL_DELAY-2:0], fill_active};
    end

    // address payload of the delay line
    always_ff @(posedge clk)
    begin
        dly_addr[0] <= fill_addr;
        for (int i = 1; i < `NABP_FILL_DELAY; i++)
            dly_addr[i] <= dly_addr[i-1];
    end

    // write lands with its own address
    always_ff @(posedge clk)
    begin
        if (dly_valid[`NABP_FILL_DELAY-1])
            mem[dly_addr[`NABP_FILL_DELAY-1]] <= port.hs_val;
    end

    // done one cycle after the last write
    always_ff @(posedge clk)
    begin
        if (reset_n)
            port.fill_done <= 1'b0;
        else
            port.fill_done <= dly_valid[`NABP_FILL_DELAY-1]
                && dly_addr[`NABP_FILL_DELAY-1] == nabp_pkg::s_addr_t'(`NABP_S_DEPTH - 1);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // two independent registered reads
    always_ff @(posedge clk)
    begin
        port.pr0_val <= mem[port.pr0_s_val];
        port.pr1_val <= mem[port.pr1_s_val];
    end

    // control must not restart this buffer while its row is still arriving
    assert property (@(posedge clk) disable iff (reset_n)
        port.fill_kick |-> !(fill_active || (|dly_valid)))
        else $error("fill kick while a fill is running");

endmodule

`default_nettype wire

// ==== verilog/nabp_filtered_ram_swap_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nabp_macros.svh"

module nabp_filtered_ram_swap_control (
    input  logic                clk,
    input  logic                reset_n,
    // host
    input  nabp_pkg::angle_t    hs_angle,
    input  logic                hs_has_next_angle,
    input  logic                hs_next_angle_ack,
    // from the ramp filter
    input  nabp_pkg::filtered_t hs_val,
    // from the processors
    input  nabp_pkg::s_addr_t   pr0_s_val,
    input  nabp_pkg::s_addr_t   pr1_s_val,
    input  logic                pr_next_angle,
    input  logic                pr_done,
    // to host RAM
    output nabp_pkg::s_addr_t   hs_s_val,
    output logic                hs_next_angle,
    // to the processors
    output nabp_pkg::angle_t    pr_angle,
    output logic                pr_next_angle_ack,
    output nabp_pkg::filtered_t pr0_val,
    output nabp_pkg::filtered_t pr1_val
);

    nabp_pkg::swap_state_t state;
    nabp_pkg::swap_state_t next_state;

    // rotate_sel is the fill buffer, the one behind it is the work buffer
    nabp_pkg::rotate_sel_t rotate_sel;
    nabp_pkg::rotate_sel_t next_sel;
    nabp_pkg::rotate_sel_t work_sel;

    logic rotate;
    logic kick;
    logic in_overlap;
    logic fill_done;
    logic fill_seen;
    logic req_seen;
    logic fill_ok;
    logic req_ok;

    // per buffer
    logic [`NABP_SWAP_COUNT-1:0] kick_vec;
    wire logic [`NABP_SWAP_COUNT-1:0] done_vec;
    wire nabp_pkg::s_addr_t hs_s_val_arr [`NABP_SWAP_COUNT];
    wire nabp_pkg::filtered_t pr0_arr [`NABP_SWAP_COUNT];
    wire nabp_pkg::filtered_t pr1_arr [`NABP_SWAP_COUNT];
    nabp_pkg::angle_t angle_arr [`NABP_SWAP_COUNT];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // rotation pointer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign next_sel = (rotate_sel == nabp_pkg::rotate_sel_t'(`NABP_SWAP_COUNT - 1))
        ? '0 : rotate_sel + 1'b1;
    assign work_sel = (rotate_sel == '0)
        ? nabp_pkg::rotate_sel_t'(`NABP_SWAP_COUNT - 1) : rotate_sel - 1'b1;

    // only the fill buffer's done counts
    assign fill_done = done_vec[rotate_sel];
    assign in_overlap = (state == nabp_pkg::fill_and_work_s)
        || (state == nabp_pkg::fill_and_work_repeat_s);

    // either half of a rotation may come first
    assign fill_ok = fill_done || fill_seen;
    assign req_ok = pr_next_angle || req_seen;

    always_comb
    begin
        case (state)
            nabp_pkg::ready_s:
                rotate = hs_next_angle_ack && hs_has_next_angle;
            nabp_pkg::fill_s:
                rotate = fill_ok;
            nabp_pkg::fill_and_work_s, nabp_pkg::fill_and_work_repeat_s:
                rotate = fill_ok && req_ok;
            default:
                rotate = 1'b0;
        endcase
    end

    // new fill only while the host still has angles
    assign kick = rotate && hs_has_next_angle;

    always_comb
    begin
        next_state = state;
        case (state)
            nabp_pkg::ready_s:
                if (rotate)
                    next_state = nabp_pkg::fill_s;
            nabp_pkg::fill_s:
                if (rotate)
                    next_state = kick ? nabp_pkg::fill_and_work_s : nabp_pkg::work_1_s;
            nabp_pkg::fill_and_work_s, nabp_pkg::fill_and_work_repeat_s:
                if (rotate)
                    next_state = kick ? nabp_pkg::fill_and_work_repeat_s : nabp_pkg::work_1_s;
            // last row in work, nothing filling
            nabp_pkg::work_1_s:
                if (pr_done)
                    next_state = nabp_pkg::ready_s;
                else if (pr_next_angle)
                    next_state = nabp_pkg::work_2_s;
            // every row read, wait for the processors to finish
            nabp_pkg::work_2_s:
                if (pr_done)
                    next_state = nabp_pkg::ready_s;
            default:
                next_state = nabp_pkg::ready_s;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            state <= nabp_pkg::ready_s;
            rotate_sel <= '0;
            fill_seen <= 1'b0;
            req_seen <= 1'b0;
        end
        else
        begin
            state <= next_state;
            if (rotate)
                rotate_sel <= next_sel;
            // hold an early half until the other one shows up
            if (rotate)
            begin
                fill_seen <= 1'b0;
                req_seen <= 1'b0;
            end
            else
            begin
                fill_seen <= fill_seen || (fill_done && in_overlap);
                req_seen <= req_seen || (pr_next_angle && in_overlap);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // kicks, angles and muxes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // kick goes to the buffer that becomes the fill buffer
    always_comb
    begin
        for (int i = 0; i < `NABP_SWAP_COUNT; i++)
            kick_vec[i] = kick && (next_sel == nabp_pkg::rotate_sel_t'(i));
    end

    // angle travels with its buffer
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < `NABP_SWAP_COUNT; i++)
            if (kick_vec[i])
                angle_arr[i] <= hs_angle;
    end

    assign hs_next_angle = kick;
    assign pr_next_angle_ack = rotate && (state != nabp_pkg::ready_s);
    assign hs_s_val = hs_s_val_arr[rotate_sel];
    assign pr_angle = angle_arr[work_sel];
    assign pr0_val = pr0_arr[work_sel];
    assign pr1_val = pr1_arr[work_sel];

    for (genvar i = 0; i < `NABP_SWAP_COUNT; i++)
    begin : gen_buf
        swap_port_if port_if ();

        // filter data and read addresses go to every buffer
        assign port_if.fill_kick = kick_vec[i];
        assign port_if.hs_val = hs_val;
        assign port_if.pr0_s_val = pr0_s_val;
        assign port_if.pr1_s_val = pr1_s_val;
        assign done_vec[i] = port_if.fill_done;
        assign hs_s_val_arr[i] = port_if.hs_s_val;
        assign pr0_arr[i] = port_if.pr0_val;
        assign pr1_arr[i] = port_if.pr1_val;

        nabp_filtered_ram_swappable u_swappable (
            .clk     (clk),
            .reset_n (reset_n),
            .port    (port_if.swappable)
        );
    end

    // pointer only walks the three buffers
    assert property (@(posedge clk) disable iff (reset_n)
        rotate_sel < `NABP_SWAP_COUNT)
        else $error("rotate_sel out of range");

endmodule

`default_nettype wire

// ==== verilog/nabp_filter_swap_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module nabp_filter_swap_top (
    input  logic                clk,
    input  logic                reset_n,
    // host
    input  nabp_pkg::angle_t    hs_angle,
    input  logic                hs_has_next_angle,
    input  logic                hs_next_angle_ack,
    input  nabp_pkg::raw_t      hs_raw,
    // processors
    input  nabp_pkg::s_addr_t   pr0_s_val,
    input  nabp_pkg::s_addr_t   pr1_s_val,
    input  logic                pr_next_angle,
    input  logic                pr_done,
    // to host RAM
    output nabp_pkg::s_addr_t   hs_s_val,
    output logic                hs_next_angle,
    // to processors
    output nabp_pkg::angle_t    pr_angle,
    output logic                pr_next_angle_ack,
    output nabp_pkg::filtered_t pr0_val,
    output nabp_pkg::filtered_t pr1_val
);

    nabp_pkg::filtered_t filtered;

    // kick cycle, then address 0, then sample 0 out of host RAM
    logic [1:0] clear_dly;

    always_ff @(posedge clk)
    begin
        if (reset_n)
            clear_dly <= '0;
        else
            clear_dly <= {clear_dly[0], hs_next_angle};
    end

    // taps clear exactly on the first sample of a row
    nabp_ramp_filter u_filter (
        .clk      (clk),
        .reset_n  (reset_n),
        .clear    (clear_dly[1]),
        .raw      (hs_raw),
        .filtered (filtered)
    );

    nabp_filtered_ram_swap_control u_control (
        .clk               (clk),
        .reset_n           (reset_n),
        .hs_angle          (hs_angle),
        .hs_has_next_angle (hs_has_next_angle),
        .hs_next_angle_ack (hs_next_angle_ack),
        .hs_val            (filtered),
        .pr0_s_val         (pr0_s_val),
        .pr1_s_val         (pr1_s_val),
        .pr_next_angle     (pr_next_angle),
        .pr_done           (pr_done),
        .hs_s_val          (hs_s_val),
        .hs_next_angle     (hs_next_angle),
        .pr_angle          (pr_angle),
        .pr_next_angle_ack (pr_next_angle_ack),
        .pr0_val           (pr0_val),
        .pr1_val           (pr1_val)
    );

endmodule

`default_nettype wire

// ==== tests/nabp_swap_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "nabp_macros.svh"

module nabp_swap_tb;

    localparam int ROWS = 4;
    // angle word plus one row of samples
    localparam int ROW_WORDS = `NABP_S_DEPTH + 1;
    localparam int RUNS = 2;
    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 16;
    // fill, read and longest stall of one row
    localparam int ROW_CYCLES = 20 + 16 + 20;
    localparam int TIMEOUT_NS = (RESET_CYCLES + RUNS * ROWS * ROW_CYCLES) * CLK_PERIOD * 2;

    logic clk = 1'b0;
    logic reset_n;

    // host side
    nabp_pkg::angle_t hs_angle;
    logic hs_has_next_angle;
    logic hs_next_angle_ack;
    nabp_pkg::raw_t hs_raw;
    nabp_pkg::s_addr_t hs_s_val;
    logic hs_next_angle;

    // processor side
    nabp_pkg::s_addr_t pr0_s_val;
    nabp_pkg::s_addr_t pr1_s_val;
    logic pr_next_angle;
    logic pr_done;
    nabp_pkg::angle_t pr_angle;
    logic pr_next_angle_ack;
    nabp_pkg::filtered_t pr0_val;
    nabp_pkg::filtered_t pr1_val;

    // trace words and the rows after the ramp filter
    logic [15:0] trace_mem [ROWS * ROW_WORDS];
    nabp_pkg::filtered_t expected [ROWS][`NABP_S_DEPTH];

    // host angle pointer and the row being fetched
    int host_idx;
    int ram_row;
    logic [31:0] rng_state;

    always #(CLK_PERIOD / 2) clk = ~clk;

    nabp_filter_swap_top uut (
        .clk               (clk),
        .reset_n           (reset_n),
        .hs_angle          (hs_angle),
        .hs_has_next_angle (hs_has_next_angle),
        .hs_next_angle_ack (hs_next_angle_ack),
        .hs_raw            (hs_raw),
        .pr0_s_val         (pr0_s_val),
        .pr1_s_val         (pr1_s_val),
        .pr_next_angle     (pr_next_angle),
        .pr_done           (pr_done),
        .hs_s_val          (hs_s_val),
        .hs_next_angle     (hs_next_angle),
        .pr_angle          (pr_angle),
        .pr_next_angle_ack (pr_next_angle_ack),
        .pr0_val           (pr0_val),
        .pr1_val           (pr1_val)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers and checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic nabp_pkg::angle_t trace_angle(input int row);
        return nabp_pkg::angle_t'(trace_mem[row * ROW_WORDS]);
    endfunction

    function automatic nabp_pkg::raw_t trace_raw(input int row, input int a);
        return nabp_pkg::raw_t'(trace_mem[row * ROW_WORDS + 1 + a]);
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // y[a] = 2x[a] - x[a-1] - x[a-2], zero before the row start
    task automatic build_expected();
        int x0;
        int x1;
        int x2;
        for (int r = 0; r < ROWS; r++)
        begin
            for (int a = 0; a < `NABP_S_DEPTH; a++)
            begin
                x0 = trace_raw(r, a);
                x1 = (a >= 1) ? int'(trace_raw(r, a - 1)) : 0;
                x2 = (a >= 2) ? int'(trace_raw(r, a - 2)) : 0;
                expected[r][a] = nabp_pkg::filtered_t'(2 * x0 - x1 - x2);
            end
        end
    endtask

    task automatic stop_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_filtered(input string name, input nabp_pkg::filtered_t got,
                                  input nabp_pkg::filtered_t want);
        if (got !== want)
            stop_run($sformatf("FAIL %s got %h expected %h at %0t ns", name, got, want, $time));
    endtask

    task automatic check_angle(input string name, input nabp_pkg::angle_t got,
                               input nabp_pkg::angle_t want);
        if (got !== want)
            stop_run($sformatf("FAIL %s got %h expected %h at %0t ns", name, got, want, $time));
    endtask

    task automatic check_addr(input string name, input nabp_pkg::s_addr_t got,
                              input nabp_pkg::s_addr_t want);
        if (got !== want)
            stop_run($sformatf("FAIL %s got %h expected %h at %0t ns", name, got, want, $time));
    endtask

    // angle levels seen by the control
    task automatic present_angle();
        hs_has_next_angle = (host_idx < ROWS);
        hs_angle = (host_idx < ROWS) ? trace_angle(host_idx) : '0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host RAM model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial
    begin : host_model
        nabp_pkg::s_addr_t addr_smp;
        nabp_pkg::s_addr_t addr_want;
        logic kick_smp;
        logic done_smp;
        int addr_left;
        $readmemh("tests/nabp_swap_trace.txt", trace_mem);
        build_expected();
        host_idx = 0;
        ram_row = 0;
        addr_left = 0;
        addr_want = '0;
        hs_raw = '0;
        present_angle();
        forever
        begin
            @(negedge clk);
            addr_smp = hs_s_val;
            kick_smp = hs_next_angle;
            done_smp = pr_done;
            // 16 addresses in order after each kick
            if (addr_left > 0)
            begin
                check_addr("hs_s_val", addr_smp, addr_want);
                addr_want = addr_want + 1'b1;
                addr_left--;
            end
            if (kick_smp === 1'b1)
            begin
                if (addr_left > 0)
                    stop_run("hs_next_angle pulsed while a row was still being fetched");
                if (host_idx >= ROWS)
                    stop_run("fill kicked although the host had no angle left");
                addr_left = `NABP_S_DEPTH;
                addr_want = '0;
            end
            @(posedge clk);
            #1;
            // one cycle of RAM latency
            hs_raw = trace_raw(ram_row, addr_smp);
            if (kick_smp === 1'b1)
            begin
                ram_row = host_idx;
                host_idx++;
                present_angle();
            end
            // rewind the trace for the next run
            if (done_smp === 1'b1)
            begin
                host_idx = 0;
                present_angle();
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // processor model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic wait_ack();
        @(negedge clk);
        while (pr_next_angle_ack !== 1'b1)
            @(negedge clk);
    endtask

    // port 0 walks up, port 1 walks down, random start
    task automatic read_row(input int row);
        nabp_pkg::s_addr_t a0;
        nabp_pkg::s_addr_t a1;
        nabp_pkg::s_addr_t prev0;
        nabp_pkg::s_addr_t prev1;
        rng_state = xorshift(rng_state);
        a0 = rng_state[3:0];
        a1 = rng_state[7:4];
        prev0 = '0;
        prev1 = '0;
        for (int i = 0; i <= `NABP_S_DEPTH; i++)
        begin
            @(posedge clk);
            #1;
            if (i < `NABP_S_DEPTH)
            begin
                pr0_s_val = a0;
                pr1_s_val = a1;
            end
            @(negedge clk);
            if (i == 0)
                check_angle("pr_angle", pr_angle, trace_angle(row));
            else
            begin
                // data of the address from the cycle before
                check_filtered("pr0_val", pr0_val, expected[row][prev0]);
                check_filtered("pr1_val", pr1_val, expected[row][prev1]);
            end
            prev0 = a0;
            prev1 = a1;
            a0 = a0 + 1'b1;
            a1 = a1 - 1'b1;
        end
    endtask

    // ack may come in the same cycle as the request
    task automatic pulse_next(output logic acked);
        @(posedge clk);
        #1;
        pr_next_angle = 1'b1;
        @(negedge clk);
        acked = (pr_next_angle_ack === 1'b1);
        @(posedge clk);
        #1;
        pr_next_angle = 1'b0;
    endtask

    task automatic run_angles();
        logic acked;
        int stall;
        // idle, no handshake without a start
        repeat (4)
        begin
            @(negedge clk);
            if (hs_next_angle !== 1'b0 || pr_next_angle_ack !== 1'b0)
                stop_run("handshake output active while idle before a start pulse");
        end
        @(posedge clk);
        #1;
        hs_next_angle_ack = 1'b1;
        @(negedge clk);
        if (hs_next_angle !== 1'b1)
            stop_run("start pulse did not kick the first fill");
        @(posedge clk);
        #1;
        hs_next_angle_ack = 1'b0;
        acked = 1'b0;
        for (int row = 0; row < ROWS; row++)
        begin
            if (!acked)
                wait_ack();
            read_row(row);
            // random stall before asking for the next row
            rng_state = xorshift(rng_state);
            stall = int'(rng_state % 21);
            repeat (stall) @(posedge clk);
            pulse_next(acked);
        end
        if (acked)
            stop_run("pr_next_angle_ack came after the last row");
        @(posedge clk);
        #1;
        pr_done = 1'b1;
        @(posedge clk);
        #1;
        pr_done = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence and watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial
    begin
        reset_n = 1'b1;
        hs_next_angle_ack = 1'b0;
        pr0_s_val = '0;
        pr1_s_val = '0;
        pr_next_angle = 1'b0;
        pr_done = 1'b0;
        rng_state = 32'h1eea_bbbf;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_n = 1'b0;
        // second run shows pr_done brought it back to ready
        for (int run = 0; run < RUNS; run++)
            run_angles();
        $display(">>> PASS");
        $finish;
    end

    initial
    begin
        #(TIMEOUT_NS);
        stop_run("timeout, the rows were not all read in time");
    end

endmodule

`default_nettype wire

// ==== tests/nabp_swap_trace.txt ====
// per row one angle word followed by 16 raw sample words
// all values hex and one per line
03
000
010
020
030
040
050
060
070
080
090
0a0
0b0
0c0
0d0
0e0
0f0
2d
fff
000
fff
000
800
7ff
001
abc
123
456
789
def
0ff
f00
555
aaa
5a
100
100
100
100
3e8
100
100
100
064
fa0
c35
100
100
100
100
007
b4
7a1
5c3
e02
019
9bd
33f
6e4
d17
0a8
f5e
271
8c6
4b9
c0d
1f2
a83

// ==== files.f ====
+incdir+include
verilog/nabp_pkg.sv
verilog/swap_port_if.sv
verilog/nabp_ramp_filter.sv
verilog/nabp_filtered_ram_swappable.sv
verilog/nabp_filtered_ram_swap_control.sv
verilog/nabp_filter_swap_top.sv
tests/nabp_swap_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal -f files.f --top-module nabp_swap_tb -o nabp_swap_sim &&
./obj_dir/nabp_swap_sim | tee /dev/stderr | grep -qx '>>> PASS' ||
exit 1
